// ==== src/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Cache geometry
`define LINE_BYTES   16   // Bytes per line, four 32-bit words
`define NUM_SETS     16   // Direct mapped, one line per set

// Backing memory
`define MEM_LINES    256  // Line addresses wrap modulo this
`define MEM_LATENCY  4    // Cycles from request to completion, at least 2

// Request buffering
`define QUEUE_DEPTH  4

`endif

// ==== src/cache_pkg.sv ====
`include "cache_config.svh"

package cache_pkg;

  localparam int OFFSET_BITS = $clog2(`LINE_BYTES);
  localparam int INDEX_BITS  = $clog2(`NUM_SETS);
  localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;

  typedef logic [31:0]              word_t;
  typedef logic [`LINE_BYTES*8-1:0] line_t;

  // Address fields, 24/4/4 with the default geometry
  typedef logic [TAG_BITS-1:0]    tag_t;
  typedef logic [INDEX_BITS-1:0]  index_t;
  typedef logic [OFFSET_BITS-1:0] offset_t;

  typedef logic [31-OFFSET_BITS:0] mem_addr_t;  // Line address toward memory

  typedef struct packed {
    tag_t    tag;
    index_t  index;
    offset_t offset;
  } addr_fields_t;

  // Same byte address, raw for line math or split for lookup
  typedef union packed {
    word_t        raw;
    addr_fields_t f;
  } cache_addr_u;

endpackage

// ==== src/req_queue.sv ====
`timescale 1ns/1ns
`include "cache_config.svh"

module req_queue (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   push,
  input  cache_pkg::cache_addr_u push_addr,
  input  logic                   push_write,
  input  cache_pkg::word_t       push_wdata,
  input  logic                   take,
  output logic                   full,
  output logic                   q_valid,
  output cache_pkg::cache_addr_u q_addr,
  output logic                   q_write,
  output cache_pkg::word_t       q_wdata
);

  localparam int PTR_BITS = (`QUEUE_DEPTH > 1) ? $clog2(`QUEUE_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(`QUEUE_DEPTH + 1);

  cache_pkg::cache_addr_u addr_mem  [`QUEUE_DEPTH];
  logic                   write_mem [`QUEUE_DEPTH];
  cache_pkg::word_t       wdata_mem [`QUEUE_DEPTH];

  logic [PTR_BITS-1:0] wr_ptr, rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                do_push, do_take;

  assign full    = (count == CNT_BITS'(`QUEUE_DEPTH));
  assign q_valid = (count != '0);
  assign do_push = push && !full;  // Strobe while full is dropped
  assign do_take = take && q_valid;

  // Head entry is always presented
  assign q_addr  = addr_mem[rd_ptr];
  assign q_write = write_mem[rd_ptr];
  assign q_wdata = wdata_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      addr_mem[wr_ptr]  <= push_addr;
      write_mem[wr_ptr] <= push_write;
      wdata_mem[wr_ptr] <= push_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_BITS'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_take)
        rd_ptr <= (rd_ptr == PTR_BITS'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_take)
        count <= count + 1'b1;
      else if (do_take && !do_push)
        count <= count - 1'b1;  // Push and take together keep the count
    end
  end

  // Producer must respect req_ready
  a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full)
    else $error("req_queue: push while full");

  // Cache only takes a presented entry
  a_no_take_empty: assert property (@(posedge clk) disable iff (reset) take |-> q_valid)
    else $error("req_queue: take while empty");

endmodule

// ==== src/data_memory.sv ====
`timescale 1ns/1ns
`include "cache_config.svh"

module data_memory (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 mem_req,
  input  logic                 mem_write,
  input  cache_pkg::mem_addr_t mem_addr,
  input  cache_pkg::line_t     mem_wline,
  output logic                 mem_ready,
  output logic                 mem_rvalid,
  output cache_pkg::line_t     mem_rline
);

  localparam int IDX_BITS = $clog2(`MEM_LINES);
  localparam int CNT_BITS = $clog2(`MEM_LATENCY);

  cache_pkg::line_t mem_array [`MEM_LINES];

  logic                busy;
  logic [CNT_BITS-1:0] cnt;      // Cycles left in the current access
  logic                wr_q;
  logic [IDX_BITS-1:0] idx_q;    // Line address modulo MEM_LINES
  cache_pkg::line_t    wline_q;
  logic                start;

  assign mem_ready = !busy;
  assign start     = mem_req && !busy;  // New access only when idle

  // Captured request, no reset needed
  always_ff @(posedge clk) begin
    if (start) begin
      wr_q    <= mem_write;
      idx_q   <= mem_addr[IDX_BITS-1:0];
      wline_q <= mem_wline;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      cnt        <= '0;
      mem_rvalid <= 1'b0;
      for (int i = 0; i < `MEM_LINES; i++)
        mem_array[i] <= '0;
    end else begin
      mem_rvalid <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= CNT_BITS'(`MEM_LATENCY - 1);
      end else if (busy) begin
        if (mem_rvalid) begin
          busy <= 1'b0;            // Read done, ready again after the data beat
        end else if (cnt == CNT_BITS'(1)) begin
          if (wr_q) begin
            mem_array[idx_q] <= wline_q;
            busy             <= 1'b0;
          end else begin
            mem_rvalid <= 1'b1;
          end
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

  // Read data beat
  always_ff @(posedge clk) begin
    if (busy && !wr_q && !mem_rvalid && cnt == CNT_BITS'(1))
      mem_rline <= mem_array[idx_q];
  end

  // A read returns its line exactly MEM_LATENCY cycles after it starts
  a_read_latency: assert property (@(posedge clk) disable iff (reset)
    mem_rvalid == $past(start && !mem_write, `MEM_LATENCY))
    else $error("data_memory: read data off the latency boundary");

endmodule

// ==== src/dm_cache.sv ====
`timescale 1ns/1ns
`include "cache_config.svh"

module dm_cache (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   q_valid,
  input  cache_pkg::cache_addr_u q_addr,
  input  logic                   q_write,
  input  cache_pkg::word_t       q_wdata,
  input  logic                   mem_ready,
  input  logic                   mem_rvalid,
  input  cache_pkg::line_t       mem_rline,
  output logic                   take,
  output logic                   resp_valid,
  output cache_pkg::word_t       resp_rdata,
  output logic                   resp_hit,
  output logic                   mem_req,
  output logic                   mem_write,
  output cache_pkg::mem_addr_t   mem_addr,
  output cache_pkg::line_t       mem_wline
);

  localparam int ADDR_LSB = 32 - $bits(cache_pkg::mem_addr_t);

  typedef enum logic [1:0] {
    IDLE,
    COMPARE_TAG,
    WRITEBACK,
    ALLOCATE
  } state_t;

  state_t state, next_state;

  cache_pkg::tag_t   tag_bank  [`NUM_SETS];
  cache_pkg::line_t  data_bank [`NUM_SETS];
  logic [`NUM_SETS-1:0] valid_bits;
  logic [`NUM_SETS-1:0] dirty_bits;

  // Request register, loaded on take
  cache_pkg::cache_addr_u req_addr;
  logic                   req_write;
  cache_pkg::word_t       req_wdata;

  logic                   missed;     // First lookup of this request missed
  logic                   issued;     // Memory accepted the current access
  cache_pkg::index_t      idx;
  logic [cache_pkg::OFFSET_BITS-3:0] word_sel;
  logic                   hit;
  cache_pkg::line_t       cur_line;
  cache_pkg::cache_addr_u victim_addr;

  assign idx      = req_addr.f.index;
  assign word_sel = req_addr.f.offset[cache_pkg::OFFSET_BITS-1:2];
  assign cur_line = data_bank[idx];
  assign hit      = valid_bits[idx] && (tag_bank[idx] == req_addr.f.tag);

  // Rebuild the victim byte address from its stored tag
  always_comb begin
    victim_addr.f.tag    = tag_bank[idx];
    victim_addr.f.index  = idx;
    victim_addr.f.offset = '0;
  end

  assign take       = (state == IDLE) && q_valid;
  assign resp_valid = (state == COMPARE_TAG) && hit;
  assign resp_rdata = req_write ? req_wdata : cur_line[word_sel*32 +: 32];
  assign resp_hit   = !missed;

  // Held until accepted, then dropped while memory is busy
  assign mem_req   = ((state == WRITEBACK) || (state == ALLOCATE)) && !issued;
  assign mem_write = (state == WRITEBACK);
  assign mem_wline = cur_line;
  assign mem_addr  = (state == WRITEBACK) ? victim_addr.raw[31:ADDR_LSB]
                                          : req_addr.raw[31:ADDR_LSB];

  always_comb begin
    next_state = state;
    case (state)
      IDLE:
        if (take) next_state = COMPARE_TAG;
      COMPARE_TAG:
        if (hit)
          next_state = IDLE;
        else if (dirty_bits[idx])
          next_state = WRITEBACK;  // Dirty victim goes out first
        else
          next_state = ALLOCATE;
      WRITEBACK:
        if (issued && mem_ready) next_state = ALLOCATE;
      ALLOCATE:
        if (mem_rvalid) next_state = COMPARE_TAG;
      default:
        next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= IDLE;
      issued <= 1'b0;
      missed <= 1'b0;
    end else begin
      state <= next_state;
      if (state != next_state)
        issued <= 1'b0;
      else if (mem_req && mem_ready)
        issued <= 1'b1;
      if (take)
        missed <= 1'b0;
      else if (state == COMPARE_TAG && !hit)
        missed <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      req_addr  <= q_addr;
      req_write <= q_write;
      req_wdata <= q_wdata;
    end
  end

  // Line data and tags
  always_ff @(posedge clk) begin
    if (state == COMPARE_TAG && hit && req_write) begin
      data_bank[idx][word_sel*32 +: 32] <= req_wdata;  // Merge one word
    end else if (state == ALLOCATE && mem_rvalid) begin
      data_bank[idx] <= mem_rline;
      tag_bank[idx]  <= req_addr.f.tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (state == COMPARE_TAG && hit && req_write) begin
      dirty_bits[idx] <= 1'b1;
    end else if (state == ALLOCATE && mem_rvalid) begin
      valid_bits[idx] <= 1'b1;
      dirty_bits[idx] <= 1'b0;  // Fresh copy matches memory
    end
  end

  // A fill makes the retried lookup hit and report the first miss
  a_fill_then_resp: assert property (@(posedge clk) disable iff (reset)
    (state == ALLOCATE) && mem_rvalid |=> resp_valid && !resp_hit)
    else $error("dm_cache: line fill not followed by a response");

  a_fill_in_allocate: assert property (@(posedge clk) disable iff (reset)
    mem_rvalid |-> (state == ALLOCATE) && issued)
    else $error("dm_cache: line fill without a pending read");

endmodule

// ==== src/cache_top.sv ====
`timescale 1ns/1ns

module cache_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_valid,
  input  cache_pkg::cache_addr_u req_addr,
  input  logic                   req_write,
  input  cache_pkg::word_t       req_wdata,
  output logic                   req_ready,
  output logic                   resp_valid,
  output cache_pkg::word_t       resp_rdata,
  output logic                   resp_hit
);

  // Queue to cache
  logic                   full;
  logic                   q_valid;
  logic                   take;
  cache_pkg::cache_addr_u q_addr;
  logic                   q_write;
  cache_pkg::word_t       q_wdata;

  // Cache to memory
  logic                   mem_req;
  logic                   mem_write;
  cache_pkg::mem_addr_t   mem_addr;
  cache_pkg::line_t       mem_wline;
  logic                   mem_ready;
  logic                   mem_rvalid;
  cache_pkg::line_t       mem_rline;

  assign req_ready = !full;

  req_queue u_queue (
    .clk        (clk),
    .reset      (reset),
    .push       (req_valid),
    .push_addr  (req_addr),
    .push_write (req_write),
    .push_wdata (req_wdata),
    .take       (take),
    .full       (full),
    .q_valid    (q_valid),
    .q_addr     (q_addr),
    .q_write    (q_write),
    .q_wdata    (q_wdata)
  );

  dm_cache u_cache (
    .clk        (clk),
    .reset      (reset),
    .q_valid    (q_valid),
    .q_addr     (q_addr),
    .q_write    (q_write),
    .q_wdata    (q_wdata),
    .mem_ready  (mem_ready),
    .mem_rvalid (mem_rvalid),
    .mem_rline  (mem_rline),
    .take       (take),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_hit   (resp_hit),
    .mem_req    (mem_req),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wline  (mem_wline)
  );

  data_memory u_mem (
    .clk        (clk),
    .reset      (reset),
    .mem_req    (mem_req),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wline  (mem_wline),
    .mem_ready  (mem_ready),
    .mem_rvalid (mem_rvalid),
    .mem_rline  (mem_rline)
  );

endmodule

// ==== tb/tb_cache_top.sv ====
`timescale 1ns/1ns
`include "cache_config.svh"

module tb_cache_top;

  localparam int RESET_CYCLES = 8;
  localparam int NUM_RANDOM   = 600;
  localparam int NUM_DIRECTED = 64;  // Upper bound on the directed requests
  localparam int WORDS        = `LINE_BYTES / 4;
  localparam int MAX_CYCLES   = (NUM_RANDOM + NUM_DIRECTED) * (2 * `MEM_LATENCY + 8)
                                + RESET_CYCLES;
  localparam int DRAIN_CYCLES = (`QUEUE_DEPTH + 2) * (2 * `MEM_LATENCY + 8);

  logic                   clk;
  logic                   reset;
  logic                   req_valid;
  cache_pkg::cache_addr_u req_addr;
  logic                   req_write;
  cache_pkg::word_t       req_wdata;
  logic                   req_ready;
  logic                   resp_valid;
  cache_pkg::word_t       resp_rdata;
  logic                   resp_hit;

  // Reference model
  cache_pkg::word_t shadow [`MEM_LINES * WORDS];  // Word-addressed backing store
  bit               mirror_valid [`NUM_SETS];
  cache_pkg::tag_t  mirror_tag [`NUM_SETS];
  cache_pkg::word_t exp_data [$];
  bit               exp_hit [$];

  cache_pkg::tag_t  tag_pool [4];
  logic [31:0]      lfsr;
  int               cycles = 0;
  bit               saw_full;

  cache_top u_dut (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .req_write  (req_write),
    .req_wdata  (req_wdata),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_hit   (resp_hit)
  );

  always #50 clk = ~clk;

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};  // One step per bit
    end
  endtask

  task automatic stop_run();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_word(input cache_pkg::word_t got, input cache_pkg::word_t want,
                            input string what);
    if (got !== want) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
      stop_run();
    end
  endtask

  task automatic check_hit(input logic got, input bit want, input string what);
    if (got !== want) begin
      $display("Error at %0t ns: %s is %0b, expected %0b", $time, what, got, want);
      stop_run();
    end
  endtask

  // Memory line wraps modulo MEM_LINES, so distinct tags may share a line
  function automatic int shadow_index(input cache_pkg::tag_t tag, input cache_pkg::index_t idx,
                                      input int word);
    int line;
    line = (int'(tag) * `NUM_SETS + int'(idx)) % `MEM_LINES;
    return line * WORDS + word;
  endfunction

  // Drive one request once the queue has room, and record what it must return
  task automatic issue(input cache_pkg::tag_t tag, input cache_pkg::index_t idx,
                       input int word, input bit wr, input cache_pkg::word_t wdata);
    cache_pkg::cache_addr_u a;
    int si;
    while (!req_ready) begin
      saw_full  = 1'b1;
      req_valid = 1'b0;
      @(posedge clk);
      #1;
    end
    a.f.tag    = tag;
    a.f.index  = idx;
    a.f.offset = cache_pkg::offset_t'(word * 4);
    req_valid  = 1'b1;
    req_addr   = a;
    req_write  = wr;
    req_wdata  = wdata;
    si = shadow_index(tag, idx, word);
    exp_hit.push_back(mirror_valid[idx] && (mirror_tag[idx] == tag));
    mirror_valid[idx] = 1'b1;  // Every access leaves its line resident
    mirror_tag[idx]   = tag;
    if (wr)
      shadow[si] = wdata;
    exp_data.push_back(shadow[si]);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    req_valid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Wait for responses up to a few worst-case misses
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_data.size() != 0 && waited < DRAIN_CYCLES) begin
      @(posedge clk);
      #1;
      waited++;
    end
  endtask

  // Responses are sampled mid-cycle
  always @(negedge clk) begin
    if (!reset && resp_valid) begin
      if (exp_data.size() == 0) begin
        $display("Unexpected response at %0t ns with no request pending", $time);
        stop_run();
      end else begin
        check_word(resp_rdata, exp_data.pop_front(), "response data");
        check_hit(resp_hit, exp_hit.pop_front(), "hit flag");
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d responses still outstanding",
               cycles, exp_data.size());
      stop_run();
    end
  end

  initial begin
    logic [31:0] v;
    logic [31:0] sel;
    logic [31:0] set;
    logic [31:0] word;
    logic [31:0] wr;
    clk       = 1'b0;
    reset     = 1'b1;
    req_valid = 1'b0;
    req_addr  = '0;
    req_write = 1'b0;
    req_wdata = '0;
    lfsr      = 32'h2ff0_aae0;
    saw_full  = 1'b0;
    for (int i = 0; i < `MEM_LINES * WORDS; i++)
      shadow[i] = '0;
    for (int i = 0; i < `NUM_SETS; i++) begin
      mirror_valid[i] = 1'b0;
      mirror_tag[i]   = '0;
    end
    tag_pool[0] = cache_pkg::tag_t'(32'h0000_0000);
    tag_pool[1] = cache_pkg::tag_t'(32'h0000_0001);
    tag_pool[2] = cache_pkg::tag_t'(32'h0000_00a2);
    tag_pool[3] = cache_pkg::tag_t'(32'h0000_0012);  // Shares memory lines with 0xa2

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    if (!req_ready || resp_valid) begin
      $display("Outputs are not idle after reset");
      stop_run();
    end

    // Cold reads miss and return zero
    for (int i = 0; i < `NUM_SETS; i++)
      issue(tag_pool[0], cache_pkg::index_t'(i), 0, 1'b0, '0);
    drain();

    // Same lines again, now resident
    for (int i = 0; i < `NUM_SETS; i++)
      issue(tag_pool[0], cache_pkg::index_t'(i), i % WORDS, 1'b0, '0);
    drain();

    // Write then read back, once on a hit and once on a miss
    issue(tag_pool[0], cache_pkg::index_t'(1), 1, 1'b1, 32'hcafe_0001);
    issue(tag_pool[0], cache_pkg::index_t'(1), 1, 1'b0, '0);
    issue(tag_pool[1], cache_pkg::index_t'(3), 2, 1'b1, 32'h1234_5678);
    issue(tag_pool[1], cache_pkg::index_t'(3), 2, 1'b0, '0);
    drain();

    // Dirty line evicted by a conflict, then read back from memory
    issue(tag_pool[0], cache_pkg::index_t'(2), 3, 1'b1, 32'hdead_beef);
    issue(tag_pool[2], cache_pkg::index_t'(2), 0, 1'b0, '0);
    issue(tag_pool[0], cache_pkg::index_t'(2), 3, 1'b0, '0);
    drain();

    // Back-to-back conflicts in one set fill the queue
    saw_full = 1'b0;
    for (int i = 0; i < 12; i++) begin
      draw_bits(32, v);
      issue(tag_pool[i % 4], cache_pkg::index_t'(5), i % WORDS, i[0], v);
    end
    if (!saw_full) begin
      $display("The queue never filled during the burst of misses");
      stop_run();
    end
    drain();

    for (int n = 0; n < NUM_RANDOM; n++) begin
      draw_bits(2, v);
      if (v[1:0] == 2'b00)
        idle(1);  // Occasional gap between requests
      draw_bits(2, sel);
      draw_bits(4, set);
      draw_bits(2, word);
      draw_bits(1, wr);
      draw_bits(32, v);
      issue(tag_pool[sel[1:0]], cache_pkg::index_t'(set[3:0]), int'(word[1:0]), wr[0], v);
    end
    drain();
    idle(4);

    if (exp_data.size() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("%0d expected responses never arrived", exp_data.size());
      stop_run();
    end
  end

endmodule

// ==== flist.f ====
+incdir+src
src/cache_pkg.sv
src/req_queue.sv
src/data_memory.sv
src/dm_cache.sv
src/cache_top.sv
tb/tb_cache_top.sv

// ==== Makefile ====
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
SEED_ARGS ?=
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
TOP       ?= tb_cache_top
FLIST     ?= flist.f

VFLAGS ?= --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR SEED_ARGS LOG BUILD_DIR"

$(BUILD_DIR)/V$(TOP): $(FLIST) $(wildcard src/*.sv src/*.svh tb/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "test passed" $(LOG) || { echo "Simulation FAILED, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
